//--- Makefile
# Verilator build and run of the multiexp engine testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_msm_top -Mdir obj_dir
	./obj_dir/Vtb_msm_top | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_msm_top.sv
/*
  Testbench for the multiexp engine.
  Affine reference model of the curve, stream drivers with scalar skew
  and result back-pressure, compare tasks and a cycle limit.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_msm_top;

  localparam longint PM = longint'(ec_field_pkg::P);
  localparam int NUM_PAIRS = 14;  // pairs sent over all tests.
  localparam int MAX_CYCLES = 40 * msm_ctrl_pkg::SCL_BITS * 20 * NUM_PAIRS;

  typedef struct packed {
    logic                    inf;
    ec_field_pkg::af_point_t pt;
  } ref_pnt_t;

  logic                              clk;
  logic                              rst;
  msm_ctrl_pkg::cnt_t                num_in;
  logic                              pnt_val;
  ec_field_pkg::af_point_t           pnt_dat;
  logic                              pnt_rdy;
  logic                              scl_val;
  msm_ctrl_pkg::scl_t                scl_dat;
  logic                              scl_rdy;
  logic                              res_val;
  logic [msm_ctrl_pkg::RES_BITS-1:0] res_dat;
  logic                              res_sop;
  logic                              res_eop;
  logic                              res_rdy;

  logic [31:0]             rng;
  int                      cycles;
  ec_field_pkg::af_point_t pts [4];
  msm_ctrl_pkg::scl_t      scls [4];
  ec_field_pkg::jb_point_t got_pnt;
  ec_field_pkg::jb_point_t saved_pnt;

  msm_top msm_top_i (
    .i_clk     ( clk     ),
    .i_rst     ( rst     ),
    .i_num_in  ( num_in  ),
    .i_pnt_val ( pnt_val ),
    .i_pnt_dat ( pnt_dat ),
    .o_pnt_rdy ( pnt_rdy ),
    .i_scl_val ( scl_val ),
    .i_scl_dat ( scl_dat ),
    .o_scl_rdy ( scl_rdy ),
    .o_res_val ( res_val ),
    .o_res_dat ( res_dat ),
    .o_res_sop ( res_sop ),
    .o_res_eop ( res_eop ),
    .i_res_rdy ( res_rdy )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic longint fmul(input longint a, input longint b);
    return (a * b) % PM;
  endfunction

  function automatic longint fsub(input longint a, input longint b);
    return (a + PM - b) % PM;
  endfunction

  function automatic longint fpow(input longint a, input longint e);
    longint r;
    longint b;
    longint k;
    r = 1;
    b = a % PM;
    k = e;
    while (k > 0) begin
      if (k[0]) r = fmul(r, b);
      b = fmul(b, b);
      k = k >> 1;
    end
    return r;
  endfunction

  // p is prime, so a^(p-2) is the inverse.
  function automatic longint finv(input longint a);
    return fpow(a, PM - 2);
  endfunction

  function automatic ref_pnt_t ref_dbl(input ref_pnt_t q);
    ref_pnt_t r;
    longint   lam;
    longint   x3;
    r = q;
    if (q.inf || q.pt.y == '0) begin
      r.inf = 1'b1;
    end else begin
      lam = fmul(fmul(3, fmul(q.pt.x, q.pt.x)), finv(fmul(2, q.pt.y)));
      x3 = fsub(fmul(lam, lam), fmul(2, q.pt.x));
      r.pt.y = 16'(fsub(fmul(lam, fsub(q.pt.x, x3)), q.pt.y));
      r.pt.x = 16'(x3);
    end
    return r;
  endfunction

  function automatic ref_pnt_t ref_add(input ref_pnt_t a, input ref_pnt_t b);
    ref_pnt_t r;
    longint   lam;
    longint   x3;
    r = '0;
    if (a.inf) return b;
    if (b.inf) return a;
    if (a.pt.x == b.pt.x) begin
      if (a.pt.y == b.pt.y) return ref_dbl(a);
      r.inf = 1'b1;  // b is the negation of a.
      return r;
    end
    lam = fmul(fsub(b.pt.y, a.pt.y), finv(fsub(b.pt.x, a.pt.x)));
    x3 = fsub(fsub(fmul(lam, lam), a.pt.x), b.pt.x);
    r.pt.y = 16'(fsub(fmul(lam, fsub(a.pt.x, x3)), a.pt.y));
    r.pt.x = 16'(x3);
    return r;
  endfunction

  function automatic ref_pnt_t ref_mul(input ref_pnt_t q, input msm_ctrl_pkg::scl_t k);
    ref_pnt_t r;
    r = '0;
    r.inf = 1'b1;
    for (int i = msm_ctrl_pkg::SCL_BITS - 1; i >= 0; i--) begin
      r = ref_dbl(r);
      if (k[i]) r = ref_add(r, q);
    end
    return r;
  endfunction

  function automatic ref_pnt_t expected_sum(input int n);
    ref_pnt_t s;
    ref_pnt_t q;
    s = '0;
    s.inf = 1'b1;
    for (int i = 0; i < n; i++) begin
      q = '{inf: 1'b0, pt: pts[i]};
      s = ref_add(s, ref_mul(q, scls[i]));
    end
    return s;
  endfunction

  // p = 3 mod 4, so rhs^((p+1)/4) is a root whenever one exists.
  task automatic pick_point(output ec_field_pkg::af_point_t pt);
    longint x;
    longint rhs;
    longint y;
    do begin
      rng = xorshift32(rng);
      x = longint'(rng[15:0]) % PM;
      rhs = (fmul(fmul(x, x), x) + longint'(ec_field_pkg::CURVE_B)) % PM;
      y = fpow(rhs, (PM + 1) / 4);
    end while (fmul(y, y) != rhs);
    pt.x = 16'(x);
    pt.y = 16'(y);
  endtask

  task automatic fail_now(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_beat(input logic [msm_ctrl_pkg::RES_BITS-1:0] got,
                            input logic [msm_ctrl_pkg::RES_BITS-1:0] exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_point(input ec_field_pkg::jb_point_t got,
                             input ec_field_pkg::af_point_t exp, input string what);
    longint zi;
    longint ax;
    longint ay;
    if (got.z === '0) begin
      fail_now($sformatf("%s: got infinity, expected (%0d, %0d)", what, exp.x, exp.y));
    end else begin
      zi = finv(got.z);
      ax = fmul(got.x, fmul(zi, zi));  // x / z^2.
      ay = fmul(got.y, fmul(zi, fmul(zi, zi)));  // y / z^3.
      if (ax != exp.x || ay != exp.y) begin
        fail_now($sformatf("%s: got (%0d, %0d), expected (%0d, %0d)",
                           what, ax, ay, exp.x, exp.y));
      end
    end
  endtask

  task automatic check_infinity(input ec_field_pkg::jb_point_t got, input string what);
    if (got.z !== '0) fail_now($sformatf("%s: z is %0d, expected infinity", what, got.z));
  endtask

  task automatic check_result(input ec_field_pkg::jb_point_t got, input ref_pnt_t exp,
                              input string what);
    if (exp.inf) check_infinity(got, what);
    else check_point(got, exp.pt, what);
  endtask

  task automatic send_points(input int n);
    for (int i = 0; i < n; i++) begin
      pnt_val <= 1'b1;
      pnt_dat <= pts[i];
      @(posedge clk);
      while (!pnt_rdy) @(posedge clk);
    end
    pnt_val <= 1'b0;
  endtask

  task automatic send_scalars(input int n, input bit skew);
    for (int i = 0; i < n; i++) begin
      if (skew) begin
        scl_val <= 1'b0;
        repeat (3 + 2 * i) @(posedge clk);  // the point waits for its scalar.
      end
      scl_val <= 1'b1;
      scl_dat <= scls[i];
      @(posedge clk);
      while (!scl_rdy) @(posedge clk);
    end
    scl_val <= 1'b0;
  endtask

  task automatic recv_result(input bit stall);
    int                                beat;
    int                                sop_cycle;
    bit                                holding;
    logic [msm_ctrl_pkg::RES_BITS-1:0] held;
    beat = 0;
    sop_cycle = 0;
    holding = 1'b0;
    held = '0;
    while (beat < 2) begin
      rng = xorshift32(rng);
      res_rdy <= stall ? (holding && rng[0]) : 1'b1;  // every beat waits at least one cycle.
      @(posedge clk);
      if (res_val) begin
        if (holding) check_beat(res_dat, held, "beat changed while stalled");
        if (res_rdy && beat == 0) begin
          check_flag(res_sop, 1'b1, "sop on beat 0");
          check_flag(res_eop, 1'b0, "eop on beat 0");
          got_pnt.x = res_dat[15:0];
          got_pnt.y = res_dat[31:16];
          sop_cycle = cycles;
        end else if (res_rdy) begin
          check_flag(res_sop, 1'b0, "sop on beat 1");
          check_flag(res_eop, 1'b1, "eop on beat 1");
          check_flag(res_dat[31:16] == '0, 1'b1, "upper half of beat 1 is zero");
          if (!stall) check_flag(cycles == sop_cycle + 1, 1'b1, "beat 1 right after beat 0");
          got_pnt.z = res_dat[15:0];
        end
        if (res_rdy) beat++;
        holding = !res_rdy;
        held = res_dat;
      end
    end
    res_rdy <= 1'b0;
  endtask

  task automatic run_batch(input int n, input bit stress);
    num_in <= msm_ctrl_pkg::cnt_t'(n);
    fork
      send_points(n);
      send_scalars(n, stress);
      recv_result(stress);
    join
  endtask

  task automatic test_single_point();
    pick_point(pts[0]);
    scls[0] = 16'd1;
    run_batch(1, 1'b0);
    check_point(got_pnt, pts[0], "scalar 1 returns the point");
  endtask

  task automatic test_infinity_cases();
    pick_point(pts[0]);
    scls[0] = 16'd0;
    run_batch(1, 1'b0);
    check_infinity(got_pnt, "scalar 0");
    pick_point(pts[0]);
    pts[1].x = pts[0].x;
    pts[1].y = 16'(fsub(0, pts[0].y));  // the negated point.
    rng = xorshift32(rng);
    scls[0] = rng[15:0];
    scls[1] = rng[15:0];
    run_batch(2, 1'b0);
    check_infinity(got_pnt, "point plus its negation");
  endtask

  task automatic test_double_branch();
    pick_point(pts[0]);
    pts[1] = pts[0];
    scls[0] = 16'd1;
    scls[1] = 16'd1;
    run_batch(2, 1'b0);
    check_result(got_pnt, ref_dbl('{inf: 1'b0, pt: pts[0]}), "point plus itself");
  endtask

  task automatic test_random_batch();
    for (int i = 0; i < 4; i++) begin
      pick_point(pts[i]);
      rng = xorshift32(rng);
      scls[i] = rng[15:0];
    end
    run_batch(4, 1'b0);
    check_result(got_pnt, expected_sum(4), "random batch of 4");
    saved_pnt = got_pnt;
  endtask

  // same inputs as the random batch, with skewed scalars and a stalling sink.
  task automatic test_skew_backpressure();
    run_batch(4, 1'b1);
    check_result(got_pnt, expected_sum(4), "batch under skew and back-pressure");
    check_beat({got_pnt.y, got_pnt.x}, {saved_pnt.y, saved_pnt.x}, "x and y match the batch");
    check_beat({16'd0, got_pnt.z}, {16'd0, saved_pnt.z}, "z matches the batch");
  endtask

  always @(posedge clk) begin
    if (!rst && ((pnt_val && pnt_rdy) != (scl_val && scl_rdy))) begin
      fail_now("a point or scalar moved without its partner");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    rng = 32'd28;
    cycles = 0;
    rst = 1'b1;
    num_in = '0;
    pnt_val = 1'b0;
    pnt_dat = '0;
    scl_val = 1'b0;
    scl_dat = '0;
    res_rdy = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_single_point();
    test_infinity_cases();
    test_double_branch();
    test_random_batch();
    test_skew_backpressure();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/ec_field_alu.sv
/*
  Field ALU over p = 65519.
  Stage one forms the product, sum or difference, stage two folds
  the result back below p. One operation per cycle, two cycle latency.
*/
`timescale 1ns/10ps
`default_nettype none

module ec_field_alu (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_issue,
  input  wire msm_ctrl_pkg::alu_op_t i_op,
  input  wire ec_field_pkg::fe_t     i_a,
  input  wire ec_field_pkg::fe_t     i_b,
  output logic                       o_done,
  output ec_field_pkg::fe_t          o_res
);

  logic        s1_vld;
  logic [31:0] s1_val;
  logic [20:0] fold1;
  logic [16:0] fold2;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_vld <= 1'b0;
      o_done <= 1'b0;
    end else begin
      s1_vld <= i_issue;
      o_done <= s1_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    case (i_op)
      msm_ctrl_pkg::ALU_MUL: s1_val <= i_a * i_b;
      msm_ctrl_pkg::ALU_ADD: s1_val <= 32'(i_a) + 32'(i_b);
      msm_ctrl_pkg::ALU_SUB: s1_val <= 32'(i_a) + 32'(ec_field_pkg::P - i_b);  // a + (p - b).
      default:               s1_val <= 32'(i_a);
    endcase
  end

  // 2^16 = 17 mod p, so two folds leave a value below 2p.
  always_comb begin
    fold1 = 21'(s1_val[31:16]) * 21'(ec_field_pkg::FOLD) + 21'(s1_val[15:0]);
    fold2 = 17'(fold1[20:16]) * 17'(ec_field_pkg::FOLD) + 17'(fold1[15:0]);
  end

  always_ff @(posedge i_clk) begin
    o_res <= (fold2 >= 17'(ec_field_pkg::P)) ? 16'(fold2 - 17'(ec_field_pkg::P)) : fold2[15:0];
  end

  a_operand_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_issue |-> (i_a < ec_field_pkg::P) && (i_b < ec_field_pkg::P))
    else $error("field operand not reduced below p");

endmodule

`default_nettype wire

//--- hdl/ec_field_pkg.sv
/*
  Field and curve definitions for the toy short-Weierstrass curve
  y^2 = x^3 + 3 over the 16-bit prime field p = 65519.
  Holds the field element type, the affine and Jacobian point types
  and the Jacobian encoding of the point at infinity.
*/
`default_nettype none

package ec_field_pkg;

  localparam int FE_BITS = 16;

  // 3 mod 4, so a square root is a single exponentiation.
  localparam logic [FE_BITS-1:0] P = 16'd65519;
  localparam logic [FE_BITS-1:0] CURVE_B = 16'd3;

  // 2^16 mod p, used to fold the high half of a product back down.
  localparam int FOLD = (1 << FE_BITS) - 65519;

  typedef logic [FE_BITS-1:0] fe_t;

  typedef struct packed {
    fe_t y;
    fe_t x;  // x sits in the low half, as on the output stream.
  } af_point_t;

  typedef struct packed {
    fe_t z;  // z = 0 marks the point at infinity.
    fe_t y;
    fe_t x;
  } jb_point_t;

  localparam jb_point_t JB_INF = '{z: 16'd0, y: 16'd1, x: 16'd1};

endpackage

`default_nettype wire

//--- hdl/msm_ctrl_pkg.sv
/*
  Control definitions for the multiexp engine.
  Scalar and batch count types, the result beat width, and the
  microcode encoding and program entry points of the execute sequencer.
*/
`default_nettype none

package msm_ctrl_pkg;

  localparam int SCL_BITS = 16;
  localparam int CNT_BITS = 8;
  localparam int RES_BITS = 32;
  localparam int REG_NUM = 12;
  localparam int PC_BITS = 6;

  typedef logic [SCL_BITS-1:0] scl_t;
  typedef logic [CNT_BITS-1:0] cnt_t;
  typedef logic [3:0] reg_idx_t;

  typedef enum logic [1:0] {ALU_MUL, ALU_ADD, ALU_SUB, ALU_PASS} alu_op_t;

  // ALU step, infinity check, H/r check, end of program.
  typedef enum logic [1:0] {UK_ALU, UK_CHK_INF, UK_CHK_H, UK_END} uop_kind_t;

  typedef struct packed {
    uop_kind_t kind;
    alu_op_t   op;
    reg_idx_t  dst;
    reg_idx_t  a;
    reg_idx_t  b;
  } uop_t;

  localparam logic [PC_BITS-1:0] PRG_ADD = 6'd0;   // general Jacobian addition.
  localparam logic [PC_BITS-1:0] PRG_DBL = 6'd26;  // Jacobian doubling for a = 0.

endpackage

`default_nettype wire

//--- hdl/msm_execute.sv
/*
  Execute stage of the multiexp engine.
  Microcoded sequencer with Jacobian doubling and addition programs,
  a field register file, one field ALU and the running batch sum.
  Each pair is multiplied MSB first by double-and-add, then summed.
*/
`timescale 1ns/10ps
`default_nettype none

module msm_execute (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic                    i_pair_val,
  input  wire ec_field_pkg::jb_point_t i_pair_pnt,
  input  wire msm_ctrl_pkg::scl_t      i_pair_scl,
  input  wire logic                    i_pair_last,
  output logic                         o_pair_rdy,
  output logic                         o_sum_val,
  output ec_field_pkg::jb_point_t      o_sum_pnt,
  input  wire logic                    i_sum_rdy
);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_NEXT, ST_PRESENT} state_t;
  typedef enum logic [1:0] {PH_DBL, PH_ADD, PH_SUM} phase_t;
  typedef logic [$clog2(msm_ctrl_pkg::SCL_BITS)-1:0] bit_idx_t;

  state_t                           state;
  phase_t                           phase;
  logic [msm_ctrl_pkg::PC_BITS-1:0] pc;
  bit_idx_t                         bit_idx;
  logic                             wait_alu;
  msm_ctrl_pkg::uop_t               cur;
  ec_field_pkg::fe_t                rf [msm_ctrl_pkg::REG_NUM];  // r0-r2 hold T, r3-r5 Q.
  ec_field_pkg::jb_point_t          pnt;
  msm_ctrl_pkg::scl_t               scl;
  logic                             last;
  ec_field_pkg::jb_point_t          sum;
  logic                             alu_issue;
  logic                             alu_done;
  ec_field_pkg::fe_t                alu_res;

  function automatic msm_ctrl_pkg::uop_t alu(msm_ctrl_pkg::alu_op_t op, int d, int a, int b);
    alu = '{kind: msm_ctrl_pkg::UK_ALU, op: op, dst: msm_ctrl_pkg::reg_idx_t'(d),
            a: msm_ctrl_pkg::reg_idx_t'(a), b: msm_ctrl_pkg::reg_idx_t'(b)};
  endfunction

  function automatic msm_ctrl_pkg::uop_t ctl(msm_ctrl_pkg::uop_kind_t k, int a, int b);
    ctl = '{kind: k, op: msm_ctrl_pkg::ALU_PASS, dst: '0,
            a: msm_ctrl_pkg::reg_idx_t'(a), b: msm_ctrl_pkg::reg_idx_t'(b)};
  endfunction

  // T += Q at 0, T = 2T at 26, both for a = 0.
  function automatic msm_ctrl_pkg::uop_t uop_rom(logic [msm_ctrl_pkg::PC_BITS-1:0] addr);
    case (addr)
      6'd0:  uop_rom = ctl(msm_ctrl_pkg::UK_CHK_INF, 2, 5);
      6'd1:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 6, 2, 2);     // z1z1.
      6'd2:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 7, 5, 5);     // z2z2.
      6'd3:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 8, 0, 7);     // u1.
      6'd4:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 9, 3, 6);     // u2.
      6'd5:  uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 9, 9, 8);     // h = u2 - u1.
      6'd6:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 10, 1, 5);
      6'd7:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 10, 10, 7);   // s1.
      6'd8:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 11, 4, 2);
      6'd9:  uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 11, 11, 6);   // s2.
      6'd10: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 11, 11, 10);  // r = s2 - s1.
      6'd11: uop_rom = ctl(msm_ctrl_pkg::UK_CHK_H, 9, 11);
      6'd12: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 2, 2, 5);
      6'd13: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 2, 2, 9);     // z3 = z1 z2 h.
      6'd14: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 6, 9, 9);     // h^2.
      6'd15: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 7, 6, 9);     // h^3.
      6'd16: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 8, 8, 6);     // v = u1 h^2.
      6'd17: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 0, 11, 11);
      6'd18: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 0, 0, 7);
      6'd19: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 0, 0, 8);
      6'd20: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 0, 0, 8);     // x3 = r^2 - h^3 - 2v.
      6'd21: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 8, 8, 0);
      6'd22: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 1, 11, 8);
      6'd23: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 10, 10, 7);
      6'd24: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 1, 1, 10);    // y3 = r(v - x3) - s1 h^3.
      6'd25: uop_rom = ctl(msm_ctrl_pkg::UK_END, 0, 0);
      6'd26: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 6, 1, 1);     // y^2.
      6'd27: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 7, 0, 6);
      6'd28: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 7, 7, 7);
      6'd29: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 7, 7, 7);     // s = 4 x y^2.
      6'd30: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 8, 0, 0);
      6'd31: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 9, 8, 8);
      6'd32: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 9, 9, 8);     // m = 3 x^2.
      6'd33: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 6, 6, 6);
      6'd34: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 6, 6, 6);
      6'd35: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 6, 6, 6);
      6'd36: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 6, 6, 6);     // 8 y^4.
      6'd37: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 2, 1, 2);
      6'd38: uop_rom = alu(msm_ctrl_pkg::ALU_ADD, 2, 2, 2);     // z3 = 2 y z.
      6'd39: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 0, 9, 9);
      6'd40: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 0, 0, 7);
      6'd41: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 0, 0, 7);     // x3 = m^2 - 2s.
      6'd42: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 10, 7, 0);
      6'd43: uop_rom = alu(msm_ctrl_pkg::ALU_MUL, 1, 9, 10);
      6'd44: uop_rom = alu(msm_ctrl_pkg::ALU_SUB, 1, 1, 6);     // y3 = m(s - x3) - 8 y^4.
      default: uop_rom = ctl(msm_ctrl_pkg::UK_END, 0, 0);       // end of the doubling.
    endcase
  endfunction

  assign cur = uop_rom(pc);
  assign alu_issue = (state == ST_RUN) && (cur.kind == msm_ctrl_pkg::UK_ALU) && !wait_alu;
  assign o_pair_rdy = (state == ST_IDLE);
  assign o_sum_val = (state == ST_PRESENT);
  assign o_sum_pnt = sum;

  ec_field_alu ec_field_alu_i (
    .i_clk   ( i_clk      ),
    .i_rst   ( i_rst      ),
    .i_issue ( alu_issue  ),
    .i_op    ( cur.op     ),
    .i_a     ( rf[cur.a]  ),
    .i_b     ( rf[cur.b]  ),
    .o_done  ( alu_done   ),
    .o_res   ( alu_res    )
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
      phase <= PH_DBL;
      pc <= '0;
      bit_idx <= '0;
      wait_alu <= 1'b0;
      sum <= ec_field_pkg::JB_INF;
    end else begin
      if (alu_issue) wait_alu <= 1'b1;
      if (alu_done) wait_alu <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_pair_val) begin
            pnt <= i_pair_pnt;
            scl <= i_pair_scl;
            last <= i_pair_last;
            rf[0] <= ec_field_pkg::JB_INF.x;  // T starts at infinity.
            rf[1] <= ec_field_pkg::JB_INF.y;
            rf[2] <= ec_field_pkg::JB_INF.z;
            bit_idx <= bit_idx_t'(msm_ctrl_pkg::SCL_BITS - 1);
            phase <= PH_DBL;
            pc <= msm_ctrl_pkg::PRG_DBL;
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          case (cur.kind)
            msm_ctrl_pkg::UK_ALU: begin
              if (alu_done) begin
                rf[cur.dst] <= alu_res;
                pc <= pc + 1'b1;
              end
            end
            msm_ctrl_pkg::UK_CHK_INF: begin
              if (rf[cur.a] == '0) begin  // T at infinity, take Q.
                rf[0] <= rf[3];
                rf[1] <= rf[4];
                rf[2] <= rf[5];
                state <= ST_NEXT;
              end else if (rf[cur.b] == '0) begin
                state <= ST_NEXT;
              end else begin
                pc <= pc + 1'b1;
              end
            end
            msm_ctrl_pkg::UK_CHK_H: begin
              if (rf[cur.a] == '0 && rf[cur.b] == '0) begin
                pc <= msm_ctrl_pkg::PRG_DBL;  // T equals Q.
              end else if (rf[cur.a] == '0) begin
                rf[2] <= '0;                  // T equals -Q.
                state <= ST_NEXT;
              end else begin
                pc <= pc + 1'b1;
              end
            end
            default: state <= ST_NEXT;
          endcase
        end
        ST_NEXT: begin
          if (phase == PH_DBL && scl[bit_idx]) begin
            rf[3] <= pnt.x;
            rf[4] <= pnt.y;
            rf[5] <= pnt.z;
            pc <= msm_ctrl_pkg::PRG_ADD;
            phase <= PH_ADD;
            state <= ST_RUN;
          end else if (phase == PH_SUM) begin
            sum <= '{z: rf[2], y: rf[1], x: rf[0]};
            state <= last ? ST_PRESENT : ST_IDLE;
          end else if (bit_idx == '0) begin  // scalar done, fold T into the sum.
            rf[3] <= sum.x;
            rf[4] <= sum.y;
            rf[5] <= sum.z;
            pc <= msm_ctrl_pkg::PRG_ADD;
            phase <= PH_SUM;
            state <= ST_RUN;
          end else begin
            bit_idx <= bit_idx - 1'b1;
            pc <= msm_ctrl_pkg::PRG_DBL;
            phase <= PH_DBL;
            state <= ST_RUN;
          end
        end
        default: begin
          if (i_sum_rdy) begin
            sum <= ec_field_pkg::JB_INF;  // the next batch starts from infinity.
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  a_sum_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_sum_val && !i_sum_rdy |=> o_sum_val && $stable(o_sum_pnt))
    else $error("batch sum changed while the result stage was stalled");

endmodule

`default_nettype wire

//--- hdl/msm_pair_decode.sv
/*
  Pair decode for the multiexp engine.
  Joins the point and scalar streams, lifts each point to Jacobian
  coordinates with z = 1 and flags the last pair of every batch.
*/
`timescale 1ns/10ps
`default_nettype none

module msm_pair_decode (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire msm_ctrl_pkg::cnt_t      i_num_in,
  input  wire logic                    i_pnt_val,
  input  wire ec_field_pkg::af_point_t i_pnt_dat,
  output logic                         o_pnt_rdy,
  input  wire logic                    i_scl_val,
  input  wire msm_ctrl_pkg::scl_t      i_scl_dat,
  output logic                         o_scl_rdy,
  output logic                         o_pair_val,
  output ec_field_pkg::jb_point_t      o_pair_pnt,
  output msm_ctrl_pkg::scl_t           o_pair_scl,
  output logic                         o_pair_last,
  input  wire logic                    i_pair_rdy
);

  msm_ctrl_pkg::cnt_t cnt;  // pairs still owed in this batch, zero between batches.
  logic xfer;
  logic first;

  // each stream only moves when the other one has a beat as well.
  assign o_pnt_rdy = i_scl_val && i_pair_rdy;
  assign o_scl_rdy = i_pnt_val && i_pair_rdy;
  assign o_pair_val = i_pnt_val && i_scl_val;

  assign o_pair_pnt = '{z: 16'd1, y: i_pnt_dat.y, x: i_pnt_dat.x};
  assign o_pair_scl = i_scl_dat;

  assign xfer = o_pair_val && i_pair_rdy;
  assign first = (cnt == '0);
  assign o_pair_last = first ? (i_num_in == 8'd1) : (cnt == 8'd1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt <= '0;
    end else if (xfer) begin
      cnt <= (first ? i_num_in : cnt) - 1'b1;  // the first pair loads the batch length.
    end
  end

  a_batch_len: assert property (@(posedge i_clk) disable iff (i_rst)
    xfer && first |-> i_num_in != '0)
    else $error("batch started with a zero length");

endmodule

`default_nettype wire

//--- hdl/msm_result.sv
/*
  Result stage of the multiexp engine.
  Takes the Jacobian batch sum and sends it as two beats,
  y and x first with sop, then z with eop.
*/
`timescale 1ns/10ps
`default_nettype none

module msm_result (
  input  wire logic                        i_clk,
  input  wire logic                        i_rst,
  input  wire logic                        i_sum_val,
  input  wire ec_field_pkg::jb_point_t     i_sum_pnt,
  output logic                             o_sum_rdy,
  output logic                             o_res_val,
  output logic [msm_ctrl_pkg::RES_BITS-1:0] o_res_dat,
  output logic                             o_res_sop,
  output logic                             o_res_eop,
  input  wire logic                        i_res_rdy
);

  logic              res_cnt;  // high while beat 1 is on the bus.
  ec_field_pkg::fe_t z_q;

  assign o_sum_rdy = !o_res_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_val <= 1'b0;
      o_res_sop <= 1'b0;
      o_res_eop <= 1'b0;
      res_cnt <= 1'b0;
    end else if (o_res_val) begin
      if (i_res_rdy && !res_cnt) begin
        res_cnt <= 1'b1;
        o_res_sop <= 1'b0;
        o_res_eop <= 1'b1;
        o_res_dat <= {16'd0, z_q};
      end else if (i_res_rdy) begin
        res_cnt <= 1'b0;
        o_res_val <= 1'b0;
        o_res_eop <= 1'b0;
      end
    end else if (i_sum_val) begin
      z_q <= i_sum_pnt.z;
      o_res_val <= 1'b1;
      o_res_sop <= 1'b1;
      o_res_dat <= {i_sum_pnt.y, i_sum_pnt.x};
    end
  end

  a_sop_eop: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_res_sop && o_res_eop))
    else $error("result beat marked as both first and last");

endmodule

`default_nettype wire

//--- hdl/msm_top.sv
/*
  Top level of the multiexp engine.
  Connects pair decode, the microcoded execute stage and the
  two-beat result stage.
*/
`timescale 1ns/10ps
`default_nettype none

module msm_top (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst,
  input  wire msm_ctrl_pkg::cnt_t           i_num_in,
  input  wire logic                         i_pnt_val,
  input  wire ec_field_pkg::af_point_t      i_pnt_dat,
  output logic                              o_pnt_rdy,
  input  wire logic                         i_scl_val,
  input  wire msm_ctrl_pkg::scl_t           i_scl_dat,
  output logic                              o_scl_rdy,
  output logic                              o_res_val,
  output logic [msm_ctrl_pkg::RES_BITS-1:0] o_res_dat,
  output logic                              o_res_sop,
  output logic                              o_res_eop,
  input  wire logic                         i_res_rdy
);

  logic                    pair_val;
  logic                    pair_rdy;
  logic                    pair_last;
  ec_field_pkg::jb_point_t pair_pnt;
  msm_ctrl_pkg::scl_t      pair_scl;
  logic                    sum_val;
  logic                    sum_rdy;
  ec_field_pkg::jb_point_t sum_pnt;

  msm_pair_decode msm_pair_decode_i (
    .i_clk       ( i_clk     ),
    .i_rst       ( i_rst     ),
    .i_num_in    ( i_num_in  ),
    .i_pnt_val   ( i_pnt_val ),
    .i_pnt_dat   ( i_pnt_dat ),
    .o_pnt_rdy   ( o_pnt_rdy ),
    .i_scl_val   ( i_scl_val ),
    .i_scl_dat   ( i_scl_dat ),
    .o_scl_rdy   ( o_scl_rdy ),
    .o_pair_val  ( pair_val  ),
    .o_pair_pnt  ( pair_pnt  ),
    .o_pair_scl  ( pair_scl  ),
    .o_pair_last ( pair_last ),
    .i_pair_rdy  ( pair_rdy  )
  );

  msm_execute msm_execute_i (
    .i_clk       ( i_clk     ),
    .i_rst       ( i_rst     ),
    .i_pair_val  ( pair_val  ),
    .i_pair_pnt  ( pair_pnt  ),
    .i_pair_scl  ( pair_scl  ),
    .i_pair_last ( pair_last ),
    .o_pair_rdy  ( pair_rdy  ),
    .o_sum_val   ( sum_val   ),
    .o_sum_pnt   ( sum_pnt   ),
    .i_sum_rdy   ( sum_rdy   )
  );

  msm_result msm_result_i (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_sum_val ( sum_val   ),
    .i_sum_pnt ( sum_pnt   ),
    .o_sum_rdy ( sum_rdy   ),
    .o_res_val ( o_res_val ),
    .o_res_dat ( o_res_dat ),
    .o_res_sop ( o_res_sop ),
    .o_res_eop ( o_res_eop ),
    .i_res_rdy ( i_res_rdy )
  );

endmodule

`default_nettype wire

//--- vlog.f
hdl/ec_field_pkg.sv
hdl/msm_ctrl_pkg.sv
hdl/msm_pair_decode.sv
hdl/ec_field_alu.sv
hdl/msm_execute.sv
hdl/msm_result.sv
hdl/msm_top.sv
dv/tb_msm_top.sv
